// File: verilog/tg_reg_pkg.sv
// Timing generator register map
// APB addresses, CTRL and CFG bit positions and the STATUS field layout
package tg_reg_pkg;

   localparam int ADDR_W = 6;

   localparam logic [ADDR_W-1:0] ADDR_CTRL   = 6'h00;  // One-cycle command strobes
   localparam logic [ADDR_W-1:0] ADDR_CFG    = 6'h04;  // Level settings, read back
   localparam logic [ADDR_W-1:0] ADDR_TQUEUE = 6'h08;  // Burst word push
   localparam logic [ADDR_W-1:0] ADDR_STATUS = 6'h0C;

   // CTRL strobes
   localparam int CTRL_ARM   = 0;
   localparam int CTRL_TRIG  = 1;
   localparam int CTRL_ABORT = 2;
   localparam int CTRL_CLEAR = 3;
   localparam int CTRL_MRST  = 4;  // Measurement sequencer reset

   // CFG levels
   localparam int CFG_W       = 4;
   localparam int CFG_TG_EN   = 0;
   localparam int CFG_SRC_EN  = 1;
   localparam int CFG_CONT    = 2;
   localparam int CFG_MEAS_EN = 3;

   // STATUS fields
   localparam int STATUS_W      = 13;
   localparam int ST_DONE       = 0;
   localparam int ST_STATE_LSB  = 1;
   localparam int ST_STATE_W    = 4;
   localparam int ST_WORDS_LSB  = 5;
   localparam int ST_WORDS_W    = 5;
   localparam int ST_BURSTS_LSB = 10;
   localparam int ST_BURSTS_W   = 3;

endpackage

// File: verilog/tg_burst_pkg.sv
// Burst parameter layout of the timing generator
// Queue sizing, timer width and the field positions of the four burst words
package tg_burst_pkg;

   localparam int WORD_W          = 32;
   localparam int WORDS_PER_BURST = 4;
   localparam int QUEUE_DEPTH     = 16;
   localparam int PTR_W           = 5;   // Counts up to a full queue
   localparam int BCNT_W          = PTR_W - $clog2(WORDS_PER_BURST);

   localparam int TIME_W = 15;  // Delays and widths in 0.1 us ticks
   localparam int CNT_W  = 12;  // Pulse and conversion counts

   // Word 0
   localparam int NP_LSB    = 0;
   localparam int TC_LSB    = 12;
   localparam int POWER_LSB = 24;
   localparam int POWER_W   = 6;

   // Word 1
   localparam int TD_LSB = 0;   // Start delay
   localparam int TO_LSB = 16;  // Conversion offset into the pulse

   // Word 2
   localparam int TW_LSB = 0;   // Pulse width
   localparam int TF_LSB = 16;  // Gap between pulses

   // Word 3
   localparam int TK_LSB   = 0;   // First measured pulse
   localparam int TS_LSB   = 12;  // Pulses skipped between conversions
   localparam int FREQ_LSB = 24;
   localparam int FREQ_W   = 7;

endpackage

// File: verilog/tg_apb_regs.sv
// APB register slave of the timing generator
// Turns writes into command strobes, CFG levels and queue pushes
`timescale 1ns/1ps

module tg_apb_regs (
   input  logic                              clk,
   input  logic                              mrst,
   input  logic                              psel_i,
   input  logic                              penable_i,
   input  logic                              pwrite_i,
   input  logic [tg_reg_pkg::ADDR_W-1:0]     paddr_i,
   input  logic [31:0]                       pwdata_i,
   output logic [31:0]                       prdata_o,
   input  logic [tg_reg_pkg::STATUS_W-1:0]   status_i,
   output logic                              q_wr_o,
   output logic [31:0]                       q_wdata_o,
   output logic                              arm_o,
   output logic                              trig_o,
   output logic                              abort_o,
   output logic                              clear_o,
   output logic                              mrst_o,
   output logic                              tg_en_o,
   output logic                              src_en_o,
   output logic                              cont_o,
   output logic                              meas_en_o
);
   import tg_reg_pkg::*;

   logic [CFG_W-1:0] cfg;
   logic             wr_en;
   logic             wr_ctrl;
   logic             wr_queue;

   assign wr_en    = psel_i & penable_i & pwrite_i;  // Access cycle of a write
   assign wr_ctrl  = wr_en && (paddr_i == ADDR_CTRL);
   assign wr_queue = wr_en && (paddr_i == ADDR_TQUEUE);

   always_ff @(posedge clk) begin
      if (mrst) begin
         arm_o   <= 1'b0;
         trig_o  <= 1'b0;
         abort_o <= 1'b0;
         clear_o <= 1'b0;
         mrst_o  <= 1'b0;
         q_wr_o  <= 1'b0;
         cfg     <= '0;
      end else begin
         // Strobes fall again on the next cycle
         arm_o   <= wr_ctrl & pwdata_i[CTRL_ARM];
         trig_o  <= wr_ctrl & pwdata_i[CTRL_TRIG];
         abort_o <= wr_ctrl & pwdata_i[CTRL_ABORT];
         clear_o <= wr_ctrl & pwdata_i[CTRL_CLEAR];
         mrst_o  <= wr_ctrl & pwdata_i[CTRL_MRST];
         q_wr_o  <= wr_queue;
         if (wr_en && (paddr_i == ADDR_CFG))
            cfg <= pwdata_i[CFG_W-1:0];
      end
   end

   always_ff @(posedge clk)
      if (wr_queue)
         q_wdata_o <= pwdata_i;

   // Read data is ready by the access cycle
   always_ff @(posedge clk) begin
      if (psel_i && !penable_i && !pwrite_i) begin
         case (paddr_i)
            ADDR_CFG:    prdata_o <= 32'(cfg);
            ADDR_STATUS: prdata_o <= 32'(status_i);
            default:     prdata_o <= '0;
         endcase
      end
   end

   assign tg_en_o   = cfg[CFG_TG_EN];
   assign src_en_o  = cfg[CFG_SRC_EN];
   assign cont_o    = cfg[CFG_CONT];
   assign meas_en_o = cfg[CFG_MEAS_EN];

endmodule

// File: verilog/tg_burst_queue.sv
// Burst parameter queue, 16 words in distributed RAM
// Filled over APB, replayed from the start on every arm
`timescale 1ns/1ps

module tg_burst_queue (
   input  logic                              clk,
   input  logic                              mrst,
   input  logic                              clear_i,
   input  logic                              q_wr_i,
   input  logic [tg_burst_pkg::WORD_W-1:0]   q_wdata_i,
   input  logic                              q_rewind_i,
   input  logic                              q_pop_i,
   output logic [tg_burst_pkg::WORD_W-1:0]   q_rdata_o,
   output logic                              q_more_o,
   output logic [tg_burst_pkg::PTR_W-1:0]    words_o,
   output logic [tg_burst_pkg::BCNT_W-1:0]   bursts_left_o
);
   import tg_burst_pkg::*;

   logic [WORD_W-1:0] ram [QUEUE_DEPTH];
   logic [PTR_W-1:0]  wr_ptr;    // Doubles as the queued word count
   logic [PTR_W-2:0]  rd_ptr;
   logic [PTR_W-1:0]  play_cnt;  // Words not yet played back
   logic              full;

   assign full = (wr_ptr == PTR_W'(QUEUE_DEPTH));

   always_ff @(posedge clk)
      if (q_wr_i && !full)
         ram[wr_ptr[PTR_W-2:0]] <= q_wdata_i;

   always_ff @(posedge clk) begin
      if (mrst || clear_i)
         wr_ptr <= '0;
      else if (q_wr_i && !full)
         wr_ptr <= wr_ptr + 1'b1;  // Writes to a full queue are dropped
   end

   // ----------------------------------------------------------------------
   // Playback side
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (mrst || clear_i) begin
         rd_ptr   <= '0;
         play_cnt <= '0;
      end else if (q_rewind_i) begin
         rd_ptr   <= '0;
         play_cnt <= wr_ptr;
      end else if (q_pop_i) begin
         rd_ptr   <= rd_ptr + 1'b1;
         play_cnt <= play_cnt - 1'b1;
      end
   end

   always_ff @(posedge clk)
      if (q_pop_i)
         q_rdata_o <= ram[rd_ptr];  // Word follows its pop by one cycle

   assign bursts_left_o = play_cnt[PTR_W-1 -: BCNT_W];  // Partial bursts do not count
   assign q_more_o      = (bursts_left_o != '0);
   assign words_o       = wr_ptr;

   // The sequencer only pops words of a burst it found complete
   a_pop_has_data: assert property (@(posedge clk) disable iff (mrst)
      q_pop_i |-> (play_cnt != '0));

endmodule

// File: verilog/tg_tick_timer.sv
// Prescaled down-counter of 0.1 us ticks
// done_o stays high while the count is zero
`timescale 1ns/1ps

module tg_tick_timer #(
   parameter int TICK_DIV = 10
) (
   input  logic                              clk,
   input  logic                              mrst,
   input  logic                              load_i,
   input  logic [tg_burst_pkg::TIME_W-1:0]   ticks_i,
   output logic                              done_o
);
   import tg_burst_pkg::*;

   localparam int PRE_W = $clog2(TICK_DIV + 1);

   logic [PRE_W-1:0]  pre;    // Clock cycles left in the current tick
   logic [TIME_W-1:0] count;

   always_ff @(posedge clk) begin
      if (mrst) begin
         pre   <= PRE_W'(TICK_DIV - 1);
         count <= '0;
      end else if (load_i) begin
         pre   <= PRE_W'(TICK_DIV - 1);  // Restart the prescaler with the count
         count <= ticks_i;
      end else if (count != '0) begin
         if (pre == '0) begin
            pre   <= PRE_W'(TICK_DIV - 1);
            count <= count - 1'b1;
         end else begin
            pre <= pre - 1'b1;
         end
      end
   end

   assign done_o = (count == '0);

   // Sequencers hold their load registers clear in reset
   a_no_load_in_reset: assert property (@(posedge clk) mrst |-> !load_i);

endmodule

// File: verilog/tg_pulse_seq.sv
// Pulse sequencer: arm, trigger, burst load and gated pulse generation
// Plays the queued bursts in order and re-arms in continuous mode
`timescale 1ns/1ps

module tg_pulse_seq #(
   parameter int TICK_DIV = 10
) (
   input  logic                              clk,
   input  logic                              mrst,
   input  logic                              arm_i,
   input  logic                              trig_i,
   input  logic                              ext_trig_i,
   input  logic                              abort_i,
   input  logic                              tg_en_i,
   input  logic                              src_en_i,
   input  logic                              cont_i,
   input  logic                              q_more_i,
   input  logic [tg_burst_pkg::WORD_W-1:0]   q_rdata_i,
   output logic                              q_rewind_o,
   output logic                              q_pop_o,
   output logic                              rf_gate_o,
   output logic                              pulse_o,
   output logic                              burst_ld_o,
   output logic [tg_burst_pkg::CNT_W-1:0]    tc_o,
   output logic [tg_burst_pkg::CNT_W-1:0]    tk_o,
   output logic [tg_burst_pkg::CNT_W-1:0]    ts_o,
   output logic [tg_burst_pkg::TIME_W-1:0]   to_o,
   output logic                              done_o,
   output logic [3:0]                        state_o
);
   import tg_burst_pkg::*;

   localparam int LD_W = $clog2(WORDS_PER_BURST) + 1;

   typedef enum logic [3:0] {
      S_IDLE, S_ARMED, S_NEXT, S_LOAD, S_START, S_OFF, S_ON
   } state_t;

   state_t            state;
   logic [WORD_W-1:0] bw [WORDS_PER_BURST];  // Words of the current burst
   logic [LD_W-1:0]   ld_cnt;
   logic [LD_W-2:0]   ld_idx;
   logic [CNT_W-1:0]  npulses;                // Pulses still to start
   logic              trig_q;
   logic              trig_rise;
   logic              tmr_load;
   logic [TIME_W-1:0] tmr_ticks;
   logic              tmr_done;
   logic              tmr_ready;

   assign trig_rise = (ext_trig_i | trig_i) & ~trig_q;
   assign tmr_ready = tmr_done & ~tmr_load;   // Count is stale in the load cycle
   assign ld_idx    = ld_cnt[LD_W-2:0] - 1'b1;

   always_ff @(posedge clk) begin
      if (mrst)
         trig_q <= 1'b0;
      else
         trig_q <= ext_trig_i | trig_i;
   end

   // Each popped word lands one cycle later
   always_ff @(posedge clk)
      if (state == S_LOAD && ld_cnt != '0)
         bw[ld_idx] <= q_rdata_i;

   // ----------------------------------------------------------------------
   // Sequencer FSM
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (mrst || abort_i || !tg_en_i) begin
         state      <= S_IDLE;
         rf_gate_o  <= 1'b0;
         pulse_o    <= 1'b0;
         tmr_load   <= 1'b0;
         q_rewind_o <= 1'b0;
         done_o     <= 1'b0;
         ld_cnt     <= '0;
         npulses    <= '0;
      end else begin
         pulse_o    <= 1'b0;
         tmr_load   <= 1'b0;
         q_rewind_o <= 1'b0;
         case (state)
            S_IDLE: if (arm_i) begin
               q_rewind_o <= 1'b1;
               done_o     <= 1'b0;
               state      <= S_ARMED;
            end
            S_ARMED: if (trig_rise) begin  // Triggers outside this state are lost
               done_o <= 1'b0;
               state  <= S_NEXT;
            end
            S_NEXT: begin
               ld_cnt <= '0;
               if (q_more_i) begin
                  state <= S_LOAD;
               end else begin
                  done_o <= 1'b1;
                  if (cont_i) begin
                     q_rewind_o <= 1'b1;
                     state      <= S_ARMED;
                  end else begin
                     state <= S_IDLE;
                  end
               end
            end
            S_LOAD: begin
               ld_cnt <= ld_cnt + 1'b1;
               if (ld_cnt == LD_W'(WORDS_PER_BURST))
                  state <= S_START;
            end
            S_START: begin
               if (bw[0][NP_LSB +: CNT_W] == '0 || bw[2][TW_LSB +: TIME_W] == '0) begin
                  state <= S_NEXT;    // Empty burst
               end else begin
                  npulses   <= bw[0][NP_LSB +: CNT_W];
                  tmr_ticks <= bw[1][TD_LSB +: TIME_W];
                  tmr_load  <= 1'b1;
                  state     <= S_OFF;
               end
            end
            S_OFF: if (tmr_ready) begin
               rf_gate_o <= src_en_i;
               pulse_o   <= 1'b1;
               npulses   <= npulses - 1'b1;
               tmr_ticks <= bw[2][TW_LSB +: TIME_W];
               tmr_load  <= 1'b1;
               state     <= S_ON;
            end
            S_ON: if (tmr_ready) begin
               rf_gate_o <= 1'b0;
               if (npulses == '0) begin
                  state <= S_NEXT;
               end else begin
                  tmr_ticks <= bw[2][TF_LSB +: TIME_W];
                  tmr_load  <= 1'b1;
                  state     <= S_OFF;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   assign q_pop_o    = (state == S_LOAD) && (ld_cnt < LD_W'(WORDS_PER_BURST));
   assign burst_ld_o = (state == S_START);
   assign tc_o       = bw[0][TC_LSB +: CNT_W];
   assign to_o       = bw[1][TO_LSB +: TIME_W];
   assign tk_o       = bw[3][TK_LSB +: CNT_W];
   assign ts_o       = bw[3][TS_LSB +: CNT_W];
   assign state_o    = state;

   tg_tick_timer #(.TICK_DIV(TICK_DIV)) u_timer (
      .clk     (clk),
      .mrst    (mrst),
      .load_i  (tmr_load),
      .ticks_i (tmr_ticks),
      .done_o  (tmr_done)
   );

   a_gate_only_on: assert property (@(posedge clk) disable iff (mrst)
      rf_gate_o |-> (state == S_ON));

endmodule

// File: verilog/tg_meas_seq.sv
// Measurement sequencer
// Picks pulses by start and skip counts and times the conversion strobe
`timescale 1ns/1ps

module tg_meas_seq #(
   parameter int TICK_DIV = 10
) (
   input  logic                              clk,
   input  logic                              mrst,
   input  logic                              mrst_i,
   input  logic                              meas_en_i,
   input  logic                              abort_i,
   input  logic                              burst_ld_i,
   input  logic                              pulse_i,
   input  logic [tg_burst_pkg::CNT_W-1:0]    tc_i,
   input  logic [tg_burst_pkg::CNT_W-1:0]    tk_i,
   input  logic [tg_burst_pkg::CNT_W-1:0]    ts_i,
   input  logic [tg_burst_pkg::TIME_W-1:0]   to_i,
   output logic                              conv_o
);
   import tg_burst_pkg::*;

   typedef enum logic [1:0] {M_IDLE, M_PULSE, M_WAIT} mstate_t;

   mstate_t           state;
   logic [CNT_W-1:0]  nconv;   // Conversions left in this burst
   logic [CNT_W-1:0]  nskip;   // Pulses to pass before the next one
   logic [CNT_W-1:0]  ts_q;
   logic [TIME_W-1:0] to_q;
   logic              tmr_load;
   logic [TIME_W-1:0] tmr_ticks;
   logic              tmr_done;

   always_ff @(posedge clk) begin
      if (mrst || mrst_i || abort_i || !meas_en_i) begin
         state    <= M_IDLE;
         conv_o   <= 1'b0;
         tmr_load <= 1'b0;
         nconv    <= '0;
         nskip    <= '0;
      end else begin
         conv_o   <= 1'b0;
         tmr_load <= 1'b0;
         if (burst_ld_i) begin
            // New burst restarts the schedule
            nconv <= tc_i;
            nskip <= tk_i;
            ts_q  <= ts_i;
            to_q  <= to_i;
            state <= (tc_i != '0) ? M_PULSE : M_IDLE;
         end else begin
            case (state)
               M_PULSE: if (pulse_i) begin
                  if (nskip == '0) begin
                     tmr_ticks <= to_q;
                     tmr_load  <= 1'b1;
                     state     <= M_WAIT;
                  end else begin
                     nskip <= nskip - 1'b1;
                  end
               end
               M_WAIT: if (tmr_done && !tmr_load) begin
                  conv_o <= 1'b1;
                  nconv  <= nconv - 1'b1;
                  nskip  <= ts_q;
                  state  <= (nconv == CNT_W'(1)) ? M_IDLE : M_PULSE;
               end
               default: state <= M_IDLE;
            endcase
         end
      end
   end

   tg_tick_timer #(.TICK_DIV(TICK_DIV)) u_timer (
      .clk     (clk),
      .mrst    (mrst),
      .load_i  (tmr_load),
      .ticks_i (tmr_ticks),
      .done_o  (tmr_done)
   );

   // One strobe per selected pulse, never stretched
   a_conv_one_cycle: assert property (@(posedge clk) disable iff (mrst)
      conv_o |=> !conv_o);

endmodule

// File: verilog/tg_top.sv
// Timing generator top level
// Register block, burst queue, pulse sequencer and measurement sequencer
`timescale 1ns/1ps

module tg_top #(
   parameter int TICK_DIV = 10
) (
   input  logic                              clk,
   input  logic                              mrst,
   input  logic                              psel_i,
   input  logic                              penable_i,
   input  logic                              pwrite_i,
   input  logic [tg_reg_pkg::ADDR_W-1:0]     paddr_i,
   input  logic [31:0]                       pwdata_i,
   output logic [31:0]                       prdata_o,
   input  logic                              ext_trig_i,
   output logic                              rf_gate_o,
   output logic                              conv_o
);
   import tg_reg_pkg::*;
   import tg_burst_pkg::*;

   logic                q_wr;
   logic [WORD_W-1:0]   q_wdata;
   logic                arm;
   logic                trig;
   logic                abort;
   logic                clear;
   logic                meas_rst;
   logic                tg_en;
   logic                src_en;
   logic                cont;
   logic                meas_en;
   logic                q_rewind;
   logic                q_pop;
   logic [WORD_W-1:0]   q_rdata;
   logic                q_more;
   logic [PTR_W-1:0]    words;
   logic [BCNT_W-1:0]   bursts_left;
   logic                pulse;
   logic                burst_ld;
   logic [CNT_W-1:0]    tc;
   logic [CNT_W-1:0]    tk;
   logic [CNT_W-1:0]    ts;
   logic [TIME_W-1:0]   to;
   logic                done;
   logic [3:0]          seq_state;
   logic [STATUS_W-1:0] status;

   // --------------------------------------------------------------------
   // STATUS word
   // --------------------------------------------------------------------
   always_comb begin
      status = '0;
      status[ST_DONE]                        = done;
      status[ST_STATE_LSB +: ST_STATE_W]     = seq_state;
      status[ST_WORDS_LSB +: ST_WORDS_W]     = words;
      status[ST_BURSTS_LSB +: ST_BURSTS_W]   = bursts_left;
   end

   tg_apb_regs u_regs (
      .clk (clk), .mrst (mrst),
      .psel_i (psel_i), .penable_i (penable_i), .pwrite_i (pwrite_i),
      .paddr_i (paddr_i), .pwdata_i (pwdata_i), .prdata_o (prdata_o),
      .status_i (status), .q_wr_o (q_wr), .q_wdata_o (q_wdata),
      .arm_o (arm), .trig_o (trig), .abort_o (abort), .clear_o (clear),
      .mrst_o (meas_rst), .tg_en_o (tg_en), .src_en_o (src_en),
      .cont_o (cont), .meas_en_o (meas_en)
   );

   tg_burst_queue u_queue (
      .clk (clk), .mrst (mrst), .clear_i (clear),
      .q_wr_i (q_wr), .q_wdata_i (q_wdata),
      .q_rewind_i (q_rewind), .q_pop_i (q_pop), .q_rdata_o (q_rdata),
      .q_more_o (q_more), .words_o (words), .bursts_left_o (bursts_left)
   );

   tg_pulse_seq #(.TICK_DIV(TICK_DIV)) u_pulse (
      .clk (clk), .mrst (mrst),
      .arm_i (arm), .trig_i (trig), .ext_trig_i (ext_trig_i), .abort_i (abort),
      .tg_en_i (tg_en), .src_en_i (src_en), .cont_i (cont),
      .q_more_i (q_more), .q_rdata_i (q_rdata),
      .q_rewind_o (q_rewind), .q_pop_o (q_pop),
      .rf_gate_o (rf_gate_o), .pulse_o (pulse), .burst_ld_o (burst_ld),
      .tc_o (tc), .tk_o (tk), .ts_o (ts), .to_o (to),
      .done_o (done), .state_o (seq_state)
   );

   tg_meas_seq #(.TICK_DIV(TICK_DIV)) u_meas (
      .clk (clk), .mrst (mrst),
      .mrst_i (meas_rst), .meas_en_i (meas_en), .abort_i (abort),
      .burst_ld_i (burst_ld), .pulse_i (pulse),
      .tc_i (tc), .tk_i (tk), .ts_i (ts), .to_i (to),
      .conv_o (conv_o)
   );

endmodule

// File: tb/tg_clk_gen.sv
// Testbench clock and reset source
// 8 ns clock, synchronous reset held for the first 4 cycles
`timescale 1ns/1ps

module tg_clk_gen (
   output logic clk,
   output logic mrst
);
   initial begin
      clk  = 1'b0;
      mrst = 1'b1;
      forever #4 clk = ~clk;
   end

   initial begin
      repeat (4) @(posedge clk);
      @(negedge clk) mrst = 1'b0;
   end

endmodule

// File: tb/tg_tb.sv
// Timing generator testbench
// Plays random bursts through the APB port and checks gate pulses and conversions
`timescale 1ns/1ps

module tg_tb;
   import tg_reg_pkg::*;
   import tg_burst_pkg::*;

   localparam int TICK_DIV = 4;

   // Sequencer state codes as read in STATUS
   localparam int SEQ_IDLE  = 0;
   localparam int SEQ_ARMED = 1;

   logic                clk;
   logic                mrst;
   logic                psel_i;
   logic                penable_i;
   logic                pwrite_i;
   logic [ADDR_W-1:0]   paddr_i;
   logic [31:0]         pwdata_i;
   logic [31:0]         prdata_o;
   logic                ext_trig_i;
   logic                rf_gate_o;
   logic                conv_o;

   logic [31:0] rng = 32'hf269;
   int          np0, tc0, td0, to0, tw0, tf0, tk0, ts0;  // Live burst fields
   int          cur_tw;
   int          cur_to;
   int          budget = 0;
   bit          budget_set = 1'b0;
   bit          aborting = 1'b0;                // Gate width is cut short on abort
   bit          gate_q = 1'b0;
   int          cyc = 0;
   int          rise_cyc = 0;
   int          pulses = 0;
   int          convs = 0;

   tg_clk_gen u_clk (.clk(clk), .mrst(mrst));

   tg_top #(.TICK_DIV(TICK_DIV)) DUT (
      .clk (clk), .mrst (mrst),
      .psel_i (psel_i), .penable_i (penable_i), .pwrite_i (pwrite_i),
      .paddr_i (paddr_i), .pwdata_i (pwdata_i), .prdata_o (prdata_o),
      .ext_trig_i (ext_trig_i), .rf_gate_o (rf_gate_o), .conv_o (conv_o)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic int draw(input int lo, input int span);
      rng = xorshift(rng);
      return lo + int'(rng % span);
   endfunction

   // Pulse i converts when it is at or past TK and on the (TS+1) grid, up to TC
   function automatic int expected_convs(input int np, input int tk, input int ts,
                                         input int tc);
      int n;
      n = 0;
      for (int i = 0; i < np; i++)
         if (i >= tk && ((i - tk) % (ts + 1)) == 0 && n < tc)
            n++;
      return n;
   endfunction

   function automatic int burst_cycles(input int td, input int np, input int tw,
                                       input int tf);
      return (td + np * (tw + tf)) * TICK_DIV + 40;
   endfunction

   task automatic value_mismatch(input string name, input int exp, input int act);
      $display("ERR %s: expected %0d, actual %0d", name, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   // ----------------------------------------------------------------------
   // APB access, driven on the falling edge
   // ----------------------------------------------------------------------
   task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
      @(negedge clk);
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = 1'b1;
      paddr_i   = addr;
      pwdata_i  = data;
      @(negedge clk) penable_i = 1'b1;
      @(negedge clk);
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
      @(negedge clk);
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = addr;
      @(negedge clk) penable_i = 1'b1;
      data = prdata_o;   // Registered at the setup edge
      @(negedge clk);
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   task automatic queue_burst(input int np, input int tc, input int td, input int to,
                              input int tw, input int tf, input int tk, input int ts);
      apb_write(ADDR_TQUEUE, 32'(np << NP_LSB) | 32'(tc << TC_LSB)
                             | 32'(draw(0, 64) << POWER_LSB));
      apb_write(ADDR_TQUEUE, 32'(td << TD_LSB) | 32'(to << TO_LSB));
      apb_write(ADDR_TQUEUE, 32'(tw << TW_LSB) | 32'(tf << TF_LSB));
      apb_write(ADDR_TQUEUE, 32'(tk << TK_LSB) | 32'(ts << TS_LSB)
                             | 32'(draw(0, 128) << FREQ_LSB));
   endtask

   task automatic fire_trigger();
      @(negedge clk) ext_trig_i = 1'b1;
      repeat (3) @(negedge clk);
      ext_trig_i = 1'b0;
   endtask

   // Run is over once the sequencer is back at idle, or armed again in continuous mode
   task automatic wait_done();
      logic [31:0] st;
      do begin
         repeat (10) @(negedge clk);
         apb_read(ADDR_STATUS, st);
      end while (st[ST_STATE_LSB +: ST_STATE_W] != SEQ_IDLE
                 && st[ST_STATE_LSB +: ST_STATE_W] != SEQ_ARMED);
   endtask

   task automatic arm_and_play();
      apb_write(ADDR_CTRL, 32'(1 << CTRL_ARM));
      fire_trigger();
      wait_done();
   endtask

   // ----------------------------------------------------------------------
   // Output monitor, sampled on the falling edge
   // ----------------------------------------------------------------------
   always @(negedge clk) begin
      if (mrst) begin
         gate_q <= 1'b0;
      end else begin
         cyc    <= cyc + 1;
         gate_q <= rf_gate_o;
         if (rf_gate_o && !gate_q) begin
            rise_cyc <= cyc;
            pulses   <= pulses + 1;
         end
         if (!rf_gate_o && gate_q && !aborting)
            assert (cyc - rise_cyc >= cur_tw * TICK_DIV
                    && cyc - rise_cyc <= cur_tw * TICK_DIV + 3)
               else value_mismatch("gate width", cur_tw * TICK_DIV, cyc - rise_cyc);
         if (conv_o) begin
            convs <= convs + 1;
            assert (cyc - rise_cyc >= cur_to * TICK_DIV + 1
                    && cyc - rise_cyc <= cur_to * TICK_DIV + 4)
               else value_mismatch("conv offset", cur_to * TICK_DIV + 1, cyc - rise_cyc);
         end
      end
   end

   a_conv_single: assert property (@(posedge clk) disable iff (mrst) conv_o |=> !conv_o)
      else abort_run("conv_o stayed high for more than one cycle");

   initial begin
      wait (budget_set);
      repeat (budget) @(posedge clk);
      abort_run("Watchdog expired before the tests completed");
   end

   // ----------------------------------------------------------------------
   // Stimulus
   // ----------------------------------------------------------------------
   initial begin
      logic [31:0] st;
      int          base;
      int          cbase;
      psel_i     = 1'b0;
      penable_i  = 1'b0;
      pwrite_i   = 1'b0;
      paddr_i    = '0;
      pwdata_i   = '0;
      ext_trig_i = 1'b0;
      @(negedge clk);
      while (mrst) @(negedge clk);

      // Reset state
      assert (rf_gate_o == 1'b0) else value_mismatch("reset gate", 0, rf_gate_o);
      assert (conv_o == 1'b0) else value_mismatch("reset conv", 0, conv_o);
      apb_read(ADDR_STATUS, st);
      assert (st[ST_STATE_LSB +: ST_STATE_W] == SEQ_IDLE)
         else value_mismatch("reset state", SEQ_IDLE, st[ST_STATE_LSB +: ST_STATE_W]);
      assert (st[ST_DONE] == 0) else value_mismatch("reset done", 0, st[ST_DONE]);
      assert (st[ST_WORDS_LSB +: ST_WORDS_W] == 0)
         else value_mismatch("reset words", 0, st[ST_WORDS_LSB +: ST_WORDS_W]);

      np0 = draw(2, 5);
      tc0 = draw(1, 4);
      td0 = draw(1, 4);
      tw0 = draw(2, 4);
      to0 = draw(0, tw0);  // Strobe stays inside the pulse
      tf0 = draw(1, 4);
      tk0 = draw(0, 3);
      ts0 = draw(0, 3);
      cur_tw = tw0;
      cur_to = to0;
      budget = 4 * burst_cycles(td0, np0, tw0, tf0) + 4000;
      budget_set = 1'b1;

      // Single burst, pulses only
      queue_burst(np0, tc0, td0, to0, tw0, tf0, tk0, ts0);
      apb_write(ADDR_CFG, 32'((1 << CFG_TG_EN) | (1 << CFG_SRC_EN)));
      base  = pulses;
      cbase = convs;
      arm_and_play();
      assert (pulses - base == np0) else value_mismatch("pulse count", np0, pulses - base);
      assert (convs == cbase) else value_mismatch("conv without meas", 0, convs - cbase);

      // Same burst with conversions
      apb_write(ADDR_CFG, 32'((1 << CFG_TG_EN) | (1 << CFG_SRC_EN) | (1 << CFG_MEAS_EN)));
      cbase = convs;
      arm_and_play();
      assert (convs - cbase == expected_convs(np0, tk0, ts0, tc0))
         else value_mismatch("conv count", expected_convs(np0, tk0, ts0, tc0), convs - cbase);

      // Empty burst ahead of a live one
      apb_write(ADDR_CTRL, 32'(1 << CTRL_CLEAR));
      queue_burst(0, 1, 1, 0, 2, 1, 0, 0);
      queue_burst(np0, tc0, td0, to0, tw0, tf0, tk0, ts0);
      apb_write(ADDR_CFG, 32'((1 << CFG_TG_EN) | (1 << CFG_SRC_EN)));
      base = pulses;
      arm_and_play();
      assert (pulses - base == np0) else value_mismatch("skip pulse count", np0, pulses - base);
      apb_read(ADDR_STATUS, st);
      assert (st[ST_DONE] == 1) else value_mismatch("done after queue", 1, st[ST_DONE]);

      // Continuous mode replay, then abort inside a pulse
      apb_write(ADDR_CFG, 32'((1 << CFG_TG_EN) | (1 << CFG_SRC_EN) | (1 << CFG_CONT)));
      base = pulses;
      arm_and_play();
      assert (pulses - base == np0) else value_mismatch("first play", np0, pulses - base);
      base = pulses;
      fire_trigger();
      while (!(rf_gate_o && pulses != base)) @(negedge clk);
      aborting = 1'b1;
      apb_write(ADDR_CTRL, 32'(1 << CTRL_ABORT));
      repeat (2) @(negedge clk);
      assert (rf_gate_o == 1'b0) else value_mismatch("gate after abort", 0, rf_gate_o);
      base = pulses;
      repeat (300) @(negedge clk);
      assert (pulses == base) else value_mismatch("pulses after abort", base, pulses);
      aborting = 1'b0;

      // Overfill and clear
      apb_write(ADDR_CTRL, 32'(1 << CTRL_CLEAR));
      for (int i = 0; i < 20; i++)
         apb_write(ADDR_TQUEUE, xorshift(32'(i + 1)));
      apb_read(ADDR_STATUS, st);
      assert (st[ST_WORDS_LSB +: ST_WORDS_W] == QUEUE_DEPTH)
         else value_mismatch("full words", QUEUE_DEPTH, st[ST_WORDS_LSB +: ST_WORDS_W]);
      apb_write(ADDR_CTRL, 32'(1 << CTRL_CLEAR));
      apb_read(ADDR_STATUS, st);
      assert (st[ST_WORDS_LSB +: ST_WORDS_W] == 0)
         else value_mismatch("cleared words", 0, st[ST_WORDS_LSB +: ST_WORDS_W]);

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// File: tg_timing.f
verilog/tg_reg_pkg.sv
verilog/tg_burst_pkg.sv
verilog/tg_apb_regs.sv
verilog/tg_burst_queue.sv
verilog/tg_tick_timer.sv
verilog/tg_pulse_seq.sv
verilog/tg_meas_seq.sv
verilog/tg_top.sv
tb/tg_clk_gen.sv
tb/tg_tb.sv

// File: Makefile
# Verilator build and run of the timing generator testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tg_timing.f --top-module tg_tb -Mdir obj_dir

run: compile
	./obj_dir/Vtg_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "Simulation finished: FAIL" $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
